// ==== Makefile ====
# Verilator build for the deobfuscation engine testbench

VERILATOR ?= verilator
TOP       ?= doe_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/doe_cipher.sv ====
/*
 * toy rotate/xor/add mix, one round per clock, not a real cipher
 * only one block in flight; init and next must not overlap the rounds
 */
`timescale 1ns/1ps
`default_nettype none
`include "doe_macros.svh"

module doe_cipher (
    input  logic                  clk,
    input  logic                  rst_b,
    input  logic                  doe_init,
    input  logic                  doe_next,
    input  logic                  src_write,
    input  logic [`DOE_BLK_W-1:0] src_data,
    output logic                  ready,
    output logic                  result_avail,
    output logic [`DOE_BLK_W-1:0] result
);
    localparam int RND_W = $clog2(`DOE_ROUNDS);

    logic [`DOE_BLK_W-1:0] chain;
    logic [`DOE_BLK_W-1:0] blk;
    logic [`DOE_BLK_W-1:0] work;
    logic [`DOE_BLK_W-1:0] work_nxt;
    logic [RND_W-1:0]      round;
    logic                  running;
    logic                  last_round;

    function automatic logic [`DOE_BLK_W-1:0] rotl(input logic [`DOE_BLK_W-1:0] v,
                                                   input int unsigned s);
        logic [2*`DOE_BLK_W-1:0] dbl;
        dbl = {v, v} << s;
        return dbl[2*`DOE_BLK_W-1:`DOE_BLK_W];
    endfunction

    // round r: xor rotated key, rotate by 13, add r
    always_comb begin
        work_nxt = work ^ rotl(`DOE_KEY, 8 * round);
        work_nxt = rotl(work_nxt, 13);
        work_nxt = work_nxt + {{(`DOE_BLK_W - RND_W){1'b0}}, round};
    end

    assign last_round = running && (round == RND_W'(`DOE_ROUNDS - 1));
    // the chain register doubles as the latched result
    assign result     = chain;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            ready        <= 1'b0;
            result_avail <= 1'b0;
            running      <= 1'b0;
            round        <= '0;
        end else if (doe_init) begin
            ready        <= 1'b1;
            result_avail <= 1'b0;
            running      <= 1'b0;
            round        <= '0;
        end else if (doe_next) begin
            ready        <= 1'b0;
            result_avail <= 1'b0;
            running      <= 1'b1;
            round        <= '0;
        end else if (running) begin
            round <= round + 1'b1;
            if (last_round) begin
                running      <= 1'b0;
                ready        <= 1'b1;
                result_avail <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (src_write) blk <= src_data;
        if (doe_init) begin
            chain <= `DOE_IV;
        end else if (last_round) begin
            chain <= work_nxt;
        end
        if (doe_next) begin
            work <= blk ^ chain;
        end else if (running) begin
            work <= work_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/doe_ctrl.sv ====
/*
 * one flow at a time; commands seen while busy are dropped
 * writes stall in WRITE until the vault returns credit
 */
`timescale 1ns/1ps
`default_nettype none
`include "doe_macros.svh"

module doe_ctrl (
    input  logic                                 clk,
    input  logic                                 rst_b,
    input  logic                                 cmd_valid,
    input  doe_pkg::doe_cmd_t                    cmd,
    input  logic [`DOE_UDS_BLOCKS*`DOE_BLK_W-1:0] obf_uds,
    input  logic [`DOE_FE_BLOCKS*`DOE_BLK_W-1:0]  obf_fe,
    output logic                                 doe_init,
    output logic                                 doe_next,
    output logic                                 src_write,
    output logic [`DOE_BLK_W-1:0]                src_data,
    input  logic                                 ready,
    input  logic                                 result_avail,
    input  logic [`DOE_BLK_W-1:0]                result,
    output doe_pkg::kv_write_t                   kv_wr,
    input  logic                                 credit_ret,
    output logic                                 busy,
    output logic                                 flow_done
);
    localparam int UDS_BW = $clog2(`DOE_UDS_BLOCKS);
    localparam int BLK_BW = $clog2(`DOE_FE_BLOCKS);
    localparam int OFS_W  = $clog2(`DOE_KV_DWORDS);
    localparam int ENT_W  = $clog2(`DOE_KV_ENTRIES);
    localparam int CRD_W  = $clog2(`DOE_KV_CREDITS + 1);

    doe_pkg::doe_state_e state, state_nxt;
    doe_pkg::doe_cmd_t   cmd_q;
    logic [BLK_BW-1:0]   block_offset;
    logic [OFS_W-1:0]    wr_offset;
    logic [ENT_W-1:0]    entry;
    logic [CRD_W-1:0]    credit_cnt;
    logic                accept;
    logic                running_uds;
    logic                last_block;
    logic                word_lo;
    logic                wr_fire;
    logic [`DOE_UDS_BLOCKS-1:0][`DOE_BLK_W-1:0] uds_blocks;
    logic [`DOE_FE_BLOCKS-1:0][`DOE_BLK_W-1:0]  fe_blocks;

    assign uds_blocks = obf_uds;
    assign fe_blocks  = obf_fe;

    assign accept      = (state == doe_pkg::IDLE) && cmd_valid && (cmd.op != doe_pkg::DOE_NOP);
    assign running_uds = (cmd_q.op == doe_pkg::DOE_UDS);
    assign last_block  = running_uds ? (block_offset == BLK_BW'(`DOE_UDS_BLOCKS - 1)) :
                                       (block_offset == BLK_BW'(`DOE_FE_BLOCKS - 1));
    // odd offsets carry the lower half of the result
    assign word_lo     = wr_offset[0];
    assign wr_fire     = (state == doe_pkg::WRITE) && (credit_cnt != '0);
    assign busy        = (state != doe_pkg::IDLE);

    // lowest block of each secret goes first
    assign src_data = running_uds ? uds_blocks[block_offset[UDS_BW-1:0]] : fe_blocks[block_offset];

    assign kv_wr.en     = wr_fire;
    assign kv_wr.entry  = entry;
    assign kv_wr.offset = wr_offset;
    assign kv_wr.data   = word_lo ? result[31:0] : result[`DOE_BLK_W-1:32];

    always_comb begin
        state_nxt = state;
        doe_init  = 1'b0;
        doe_next  = 1'b0;
        src_write = 1'b0;
        flow_done = 1'b0;
        case (state)
            doe_pkg::IDLE: if (accept) state_nxt = doe_pkg::INIT;
            doe_pkg::INIT: begin
                doe_init  = 1'b1;
                state_nxt = doe_pkg::WAIT;
            end
            // ready alone means load the next block, with a result it means write
            doe_pkg::WAIT: if (ready) state_nxt = result_avail ? doe_pkg::WRITE : doe_pkg::BLOCK;
            doe_pkg::BLOCK: begin
                src_write = 1'b1;
                state_nxt = doe_pkg::NEXT;
            end
            doe_pkg::NEXT: begin
                doe_next  = 1'b1;
                state_nxt = doe_pkg::WAIT;
            end
            doe_pkg::WRITE: begin
                if (wr_fire && word_lo) state_nxt = last_block ? doe_pkg::DONE : doe_pkg::BLOCK;
            end
            doe_pkg::DONE: begin
                flow_done = 1'b1;
                state_nxt = doe_pkg::IDLE;
            end
            default: state_nxt = doe_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state        <= doe_pkg::IDLE;
            cmd_q        <= '0;
            block_offset <= '0;
            wr_offset    <= '0;
            entry        <= '0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                cmd_q <= cmd;
                entry <= cmd.dest_sel;
            end
            if (wr_fire) begin
                wr_offset <= wr_offset + 1'b1;
                // entry full, roll into the next one (wraps mod 8)
                if (wr_offset == '1) entry <= entry + 1'b1;
                if (word_lo && !last_block) block_offset <= block_offset + 1'b1;
            end
            if (state == doe_pkg::DONE) begin
                block_offset <= '0;
                wr_offset    <= '0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            credit_cnt <= CRD_W'(`DOE_KV_CREDITS);
        end else begin
            case ({wr_fire, credit_ret})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/doe_macros.svh ====
/*
 * key and iv are fixed build-time constants, not secret material
 * block and credit counts are sized for power-of-two buffer depths
 */
`ifndef DOE_MACROS_SVH
`define DOE_MACROS_SVH

// cipher datapath
`define DOE_BLK_W 64
`define DOE_ROUNDS 8
`define DOE_KEY 64'hbb67_ae85_84ca_a73b
`define DOE_IV 64'h6a09_e667_f3bc_c908

// blocks per obfuscated secret
`define DOE_UDS_BLOCKS 2
`define DOE_FE_BLOCKS 4

// vault geometry, 32-bit words per entry
`define DOE_KV_ENTRIES 8
`define DOE_KV_DWORDS 4

// write buffer depth, also the initial credit count
`define DOE_KV_CREDITS 2

`endif

// ==== rtl/doe_pkg.sv ====
/*
 * shared types for the deobfuscation engine and its key vault
 * field widths assume an 8-entry vault of 4 dwords each
 */
`default_nettype none

package doe_pkg;

    // command opcodes, NOP is never accepted
    typedef enum logic [1:0] {
        DOE_NOP = 2'd0,
        DOE_UDS = 2'd1,
        DOE_FE  = 2'd2
    } doe_op_e;

    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        INIT  = 3'd1,
        BLOCK = 3'd2,
        NEXT  = 3'd3,
        WAIT  = 3'd4,
        WRITE = 3'd5,
        DONE  = 3'd6
    } doe_state_e;

    typedef struct packed {
        doe_op_e    op;
        logic [2:0] dest_sel;
    } doe_cmd_t;

    typedef struct packed {
        logic        en;
        logic [2:0]  entry;
        logic [1:0]  offset;
        logic [31:0] data;
    } kv_write_t;

    // external read, data returns one cycle later
    typedef struct packed {
        logic       en;
        logic [2:0] entry;
        logic [1:0] offset;
    } kv_read_t;

endpackage

`default_nettype wire

// ==== rtl/doe_top.sv ====
/*
 * external reads take priority and can stall a running flow
 */
`timescale 1ns/1ps
`default_nettype none
`include "doe_macros.svh"

module doe_top (
    input  logic                                 clk,
    input  logic                                 rst_b,
    input  logic                                 cmd_valid,
    input  doe_pkg::doe_cmd_t                    cmd,
    input  logic [`DOE_UDS_BLOCKS*`DOE_BLK_W-1:0] obf_uds,
    input  logic [`DOE_FE_BLOCKS*`DOE_BLK_W-1:0]  obf_fe,
    input  doe_pkg::kv_read_t                    kv_rd,
    output logic [31:0]                          rd_data,
    output logic                                 busy,
    output logic                                 flow_done
);
    logic                  doe_init;
    logic                  doe_next;
    logic                  src_write;
    logic [`DOE_BLK_W-1:0] src_data;
    logic                  ready;
    logic                  result_avail;
    logic [`DOE_BLK_W-1:0] result;
    doe_pkg::kv_write_t    kv_wr;
    logic                  credit_ret;

    doe_ctrl u_ctrl (
        .clk          (clk),
        .rst_b        (rst_b),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .obf_uds      (obf_uds),
        .obf_fe       (obf_fe),
        .doe_init     (doe_init),
        .doe_next     (doe_next),
        .src_write    (src_write),
        .src_data     (src_data),
        .ready        (ready),
        .result_avail (result_avail),
        .result       (result),
        .kv_wr        (kv_wr),
        .credit_ret   (credit_ret),
        .busy         (busy),
        .flow_done    (flow_done)
    );

    doe_cipher u_cipher (
        .clk          (clk),
        .rst_b        (rst_b),
        .doe_init     (doe_init),
        .doe_next     (doe_next),
        .src_write    (src_write),
        .src_data     (src_data),
        .ready        (ready),
        .result_avail (result_avail),
        .result       (result)
    );

    key_vault u_vault (
        .clk        (clk),
        .rst_b      (rst_b),
        .kv_wr      (kv_wr),
        .kv_rd      (kv_rd),
        .rd_data    (rd_data),
        .credit_ret (credit_ret)
    );

endmodule

`default_nettype wire

// ==== rtl/key_vault.sv ====
/*
 * buffered writes are invisible to reads until retired
 * buffer depth must be a power of two; overflow is prevented by credits
 */
`timescale 1ns/1ps
`default_nettype none
`include "doe_macros.svh"

module key_vault (
    input  logic               clk,
    input  logic               rst_b,
    input  doe_pkg::kv_write_t kv_wr,
    input  doe_pkg::kv_read_t  kv_rd,
    output logic [31:0]        rd_data,
    output logic               credit_ret
);
    localparam int SLOT_W = $clog2(`DOE_KV_CREDITS);
    localparam int CNT_W  = $clog2(`DOE_KV_CREDITS + 1);

    doe_pkg::kv_write_t slots [`DOE_KV_CREDITS];
    doe_pkg::kv_write_t head;
    logic [SLOT_W-1:0]  wr_ptr;
    logic [SLOT_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               retire;
    logic [31:0]        store [`DOE_KV_ENTRIES][`DOE_KV_DWORDS];

    assign head = slots[rd_ptr];
    // reads own the array port, retirement waits
    assign retire = (count != '0) && !kv_rd.en;

    always_ff @(posedge clk) begin
        if (kv_wr.en) slots[wr_ptr] <= kv_wr;
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_ret <= 1'b0;
        end else begin
            credit_ret <= retire;
            if (kv_wr.en) wr_ptr <= wr_ptr + 1'b1;
            if (retire) rd_ptr <= rd_ptr + 1'b1;
            case ({kv_wr.en, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // vault contents must read zero after reset
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            for (int e = 0; e < `DOE_KV_ENTRIES; e++) begin
                for (int w = 0; w < `DOE_KV_DWORDS; w++) begin
                    store[e][w] <= '0;
                end
            end
        end else if (retire) begin
            store[head.entry][head.offset] <= head.data;
        end
    end

    always_ff @(posedge clk) begin
        if (kv_rd.en) rd_data <= store[kv_rd.entry][kv_rd.offset];
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+rtl
rtl/doe_pkg.sv
rtl/doe_cipher.sv
rtl/key_vault.sv
rtl/doe_ctrl.sv
rtl/doe_top.sv
tests/doe_chk.sv
tests/doe_tb.sv

// ==== tests/doe_chk.sv ====
/*
 * credit and pulse rules bound into doe_ctrl and key_vault
 * a count that wraps below zero shows up as a value above the limit
 */
`timescale 1ns/1ps
`default_nettype none
`include "doe_macros.svh"

module doe_chk #(
    parameter int FULL_AT   = 0,
    parameter bit HAS_PULSE = 1'b1
) (
    input logic                                   clk,
    input logic                                   rst_b,
    input logic [$clog2(`DOE_KV_CREDITS + 1)-1:0] level,
    input logic                                   issue,
    input logic                                   pulse
);
    localparam int LVL_W = $clog2(`DOE_KV_CREDITS + 1);

    logic blocked;

    // level where a new write would be illegal
    assign blocked = (level == LVL_W'(FULL_AT));

    a_level_range: assert property (@(posedge clk) disable iff (!rst_b)
        level <= LVL_W'(`DOE_KV_CREDITS))
        else $error("credit level outside 0..%0d", `DOE_KV_CREDITS);

    a_no_blocked_write: assert property (@(posedge clk) disable iff (!rst_b)
        !(issue && blocked))
        else $error("write issued at blocking credit level");

    if (HAS_PULSE) begin : g_pulse
        a_single_pulse: assert property (@(posedge clk) disable iff (!rst_b)
            pulse |=> !pulse)
            else $error("done pulse held longer than one cycle");
    end

endmodule

bind doe_ctrl doe_chk #(.FULL_AT(0)) u_ctrl_chk (
    .clk   (clk),
    .rst_b (rst_b),
    .level (credit_cnt),
    .issue (kv_wr.en),
    .pulse (flow_done)
);

// buffer occupancy mirrors the credits and full means no room
// the vault has no done pulse of its own
bind key_vault doe_chk #(.FULL_AT(`DOE_KV_CREDITS), .HAS_PULSE(1'b0)) u_vault_chk (
    .clk   (clk),
    .rst_b (rst_b),
    .level (count),
    .issue (kv_wr.en),
    .pulse (1'b0)
);

`default_nettype wire

// ==== tests/doe_tb.sv ====
/*
 * readback assumes an 8x4 vault; it starts only after the write buffer drains
 * secrets stay stable for the whole flow
 */
`timescale 1ns/1ps
`default_nettype none
`include "doe_macros.svh"

module doe_tb;
    localparam int PERIOD      = 10;
    localparam int RESET_CYC   = 8;
    localparam int UDS_W       = `DOE_UDS_BLOCKS * `DOE_BLK_W;
    localparam int FE_W        = `DOE_FE_BLOCKS * `DOE_BLK_W;
    localparam int N_WORDS     = `DOE_KV_ENTRIES * `DOE_KV_DWORDS;
    localparam int N_FLOWS     = 7;
    localparam int STALL_CYC   = 300;
    localparam int FLOW_LIMIT  = `DOE_FE_BLOCKS * (`DOE_ROUNDS + 6) + STALL_CYC;
    localparam int WATCHDOG_NS = (N_FLOWS * FLOW_LIMIT + RESET_CYC) * PERIOD;
    localparam logic [31:0] SEED = 32'h5af3_5023;

    logic              clk;
    logic              rst_b;
    logic              cmd_valid;
    doe_pkg::doe_cmd_t cmd;
    logic [UDS_W-1:0]  obf_uds;
    logic [FE_W-1:0]   obf_fe;
    doe_pkg::kv_read_t kv_rd;
    logic [31:0]       rd_data;
    logic              busy;
    logic              flow_done;

    logic [31:0] exp_vault [`DOE_KV_ENTRIES][`DOE_KV_DWORDS];
    logic [31:0] lfsr_q;
    logic [31:0] bp_lfsr;
    logic        bp_en;
    int          check_seq = 0;
    int          done_seq = 0;
    int          word_errs = 0;
    int          status_errs = 0;
    int          word_checks = 0;
    int          status_checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    doe_top UUT (
        .clk       (clk),
        .rst_b     (rst_b),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .obf_uds   (obf_uds),
        .obf_fe    (obf_fe),
        .kv_rd     (kv_rd),
        .rd_data   (rd_data),
        .busy      (busy),
        .flow_done (flow_done)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout at %0t: tests did not finish within %0d ns", $time, WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    // galois form with taps 32 30 26 25
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    function automatic logic [63:0] rot_left(input logic [63:0] v, input int s);
        return (v << s) | (v >> (64 - s));
    endfunction

    // expected cipher output for one block given the running chain value
    function automatic logic [63:0] ref_block(input logic [63:0] blk, input logic [63:0] chain);
        logic [63:0] w;
        w = blk ^ chain;
        for (int r = 0; r < `DOE_ROUNDS; r++) begin
            w = w ^ rot_left(`DOE_KEY, 8 * r);
            w = rot_left(w, 13);
            w = w + 64'(r);
        end
        return w;
    endfunction

    task automatic draw_bits(input int n, output logic [FE_W-1:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[FE_W-2:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    task automatic randomize_secrets();
        logic [FE_W-1:0] r;
        draw_bits(UDS_W, r);
        obf_uds = r[UDS_W-1:0];
        draw_bits(FE_W, r);
        obf_fe = r;
    endtask

    // two words per block with the upper half first and entries wrapping mod 8
    task automatic model_flow(input doe_pkg::doe_op_e op, input logic [2:0] dest,
                              input logic [UDS_W-1:0] uds, input logic [FE_W-1:0] fe);
        logic [63:0] chain;
        logic [63:0] blk;
        logic [2:0]  ent;
        logic [1:0]  ofs;
        int          nblk;
        chain = `DOE_IV;
        nblk  = (op == doe_pkg::DOE_UDS) ? `DOE_UDS_BLOCKS : `DOE_FE_BLOCKS;
        for (int b = 0; b < nblk; b++) begin
            if (op == doe_pkg::DOE_UDS) begin
                blk = 64'(uds >> (b * `DOE_BLK_W));
            end else begin
                blk = 64'(fe >> (b * `DOE_BLK_W));
            end
            chain = ref_block(blk, chain);
            ent   = dest + 3'((2 * b) / `DOE_KV_DWORDS);
            ofs   = 2'((2 * b) % `DOE_KV_DWORDS);
            exp_vault[ent][ofs]        = chain[63:32];
            exp_vault[ent][ofs + 2'd1] = chain[31:0];
        end
    endtask

    task automatic compare_word(input logic [31:0] got, input logic [31:0] want,
                                input string what);
        word_checks++;
        if (got !== want) begin
            word_errs++;
            $display("Mismatch at %0t: %s got %08h expected %08h", $time, what, got, want);
        end
    endtask

    task automatic expect_status(input logic want_busy, input logic want_done,
                                 input string what);
        status_checks++;
        if (busy !== want_busy || flow_done !== want_done) begin
            status_errs++;
            $display("Mismatch at %0t: %s busy/flow_done got %b/%b expected %b/%b",
                     $time, what, busy, flow_done, want_busy, want_done);
        end
    endtask

    task automatic issue_cmd(input doe_pkg::doe_op_e op, input logic [2:0] dest);
        cmd_valid    = 1'b1;
        cmd.op       = op;
        cmd.dest_sel = dest;
        @(negedge clk);
        cmd_valid = 1'b0;
        expect_status(1'b1, 1'b0, "after command");
    endtask

    task automatic finish_flow(input doe_pkg::doe_op_e op, input logic [2:0] dest);
        int cycles;
        cycles = 0;
        while (flow_done !== 1'b1 && cycles < FLOW_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (flow_done !== 1'b1) begin
            status_errs++;
            $display("Error at %0t: flow_done did not arrive within %0d cycles",
                     $time, FLOW_LIMIT);
        end else begin
            expect_status(1'b1, 1'b1, "done cycle");
        end
        model_flow(op, dest, obf_uds, obf_fe);
        @(negedge clk);
        expect_status(1'b0, 1'b0, "after done");
    endtask

    task automatic run_flow(input doe_pkg::doe_op_e op, input logic [2:0] dest);
        issue_cmd(op, dest);
        finish_flow(op, dest);
    endtask

    // let the buffer retire before the compare process reads back
    task automatic verify_vault();
        repeat (`DOE_KV_CREDITS + 2) @(negedge clk);
        check_seq++;
        wait (done_seq == check_seq);
    endtask

    task automatic end_test(input string name, input int base);
        tests_run++;
        if (word_errs + status_errs != base) begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
    endtask

    // drives kv_rd for vault readback and for background reads that cause back-pressure
    initial begin : compare_proc
        logic [4:0] addr;
        logic [6:0] rb;
        kv_rd   = '0;
        bp_lfsr = SEED;
        rb      = '0;
        forever begin
            @(negedge clk);
            if (done_seq != check_seq) begin
                for (int i = 0; i < N_WORDS; i++) begin
                    addr         = 5'(i);
                    kv_rd.en     = 1'b1;
                    kv_rd.entry  = addr[4:2];
                    kv_rd.offset = addr[1:0];
                    @(negedge clk);
                    compare_word(rd_data, exp_vault[addr[4:2]][addr[1:0]],
                                 $sformatf("entry %0d word %0d", addr[4:2], addr[1:0]));
                end
                kv_rd    = '0;
                done_seq = check_seq;
            end else if (bp_en) begin
                for (int i = 0; i < 7; i++) begin
                    rb      = {rb[5:0], bp_lfsr[0]};
                    bp_lfsr = lfsr_step(bp_lfsr);
                end
                // reads on three cycles in four on average
                kv_rd.en     = (rb[6:5] != 2'b00);
                kv_rd.entry  = rb[4:2];
                kv_rd.offset = rb[1:0];
            end else begin
                kv_rd = '0;
            end
        end
    end

    initial begin : stimulus
        logic [FE_W-1:0] r;
        logic [2:0]      dest;
        int              base;
        lfsr_q    = SEED;
        bp_en     = 1'b0;
        rst_b     = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        obf_uds   = '0;
        obf_fe    = '0;
        exp_vault = '{default: '0};
        repeat (RESET_CYC) @(negedge clk);
        rst_b = 1'b1;

        base = word_errs + status_errs;
        expect_status(1'b0, 1'b0, "after reset");
        verify_vault();
        end_test("reset state", base);

        base = word_errs + status_errs;
        randomize_secrets();
        draw_bits(3, r);
        dest = r[2:0];
        run_flow(doe_pkg::DOE_UDS, dest);
        verify_vault();
        end_test("uds flow to random entry", base);

        base = word_errs + status_errs;
        randomize_secrets();
        run_flow(doe_pkg::DOE_FE, 3'd7);
        verify_vault();
        end_test("fe flow wrapping 7 to 0", base);

        base = word_errs + status_errs;
        randomize_secrets();
        draw_bits(3, r);
        dest  = r[2:0];
        bp_en = 1'b1;
        run_flow(doe_pkg::DOE_FE, dest);
        bp_en = 1'b0;
        verify_vault();
        end_test("fe flow under read back-pressure", base);

        base = word_errs + status_errs;
        randomize_secrets();
        draw_bits(3, r);
        dest = r[2:0];
        issue_cmd(doe_pkg::DOE_FE, dest);
        repeat (3) @(negedge clk);
        // dropped while busy so its entry keeps the old contents
        issue_cmd(doe_pkg::DOE_UDS, dest + 3'd4);
        finish_flow(doe_pkg::DOE_FE, dest);
        repeat (4) begin
            @(negedge clk);
            expect_status(1'b0, 1'b0, "idle after ignored command");
        end
        verify_vault();
        end_test("command while busy ignored", base);

        base = word_errs + status_errs;
        randomize_secrets();
        draw_bits(3, r);
        dest = r[2:0];
        run_flow(doe_pkg::DOE_UDS, dest);
        draw_bits(3, r);
        dest = r[2:0];
        run_flow(doe_pkg::DOE_FE, dest);
        verify_vault();
        end_test("back-to-back uds then fe", base);

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors", tests_run,
                 tests_failed, word_checks + status_checks, word_errs + status_errs);
        if (tests_failed == 0 && word_errs + status_errs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
